// File: hw/snd_defs.svh
// Sound DAC parameters
`ifndef SND_DEFS_SVH
`define SND_DEFS_SVH

// clk_dac cycles per modulator clock enable
// Also the width of the one-hot ring in the enable generator
`define SND_CEN_DIV 4

// Zero bits appended below the 16-bit sample
// 1 + 16 + 3 gives the 20-bit modulator word
`define SND_PAD_LSB 3

// Integrator width
// Input full scale is 2^19, so 23 bits leave room for
// the second integrator to swing several times full scale
`define SND_ACC_W 23

// Density measurement window, in clock enables
// Tied to the enable divide above, one window lasts
// SND_WIN * SND_CEN_DIV clk_dac cycles
`define SND_WIN 256

`endif

// File: hw/snd_pcm_pkg.sv
// PCM sample types
`default_nettype none

`include "snd_defs.svh"

package snd_pcm_pkg;

    // One audio sample as delivered by the game core
    // Signed or offset binary depending on the core
    typedef logic [15:0] pcm16_t;

    // Modulator input word
    // Bit layout from MSB down: one zero, the converted sample,
    // then SND_PAD_LSB zeros. The zero MSB keeps the value
    // strictly below the feedback full scale.
    typedef logic [$bits(pcm16_t)+`SND_PAD_LSB:0] pcm_pad_t;

    // Stereo sample pair from the core
    // Left sits in the upper half
    typedef struct packed {
        pcm16_t left;
        pcm16_t right;
    } pcm_pair_t;

endpackage

`default_nettype wire

// File: hw/snd_dac_pkg.sv
// Modulator loop types
`default_nettype none

`include "snd_defs.svh"

package snd_dac_pkg;

    // Integrator state, signed, with headroom above the 20-bit input
    typedef logic signed [`SND_ACC_W-1:0] sd_acc_t;

    // Feedback from the output bit, either full scale or zero
    typedef logic signed [`SND_ACC_W-1:0] sd_fb_t;

    // Symmetric saturation of an integrator value
    function automatic sd_acc_t sd_clip(
        input sd_acc_t value,
        input sd_acc_t limit
    );
        sd_acc_t result;
        if (value > limit) begin
            result = limit;
        end else if (value < -limit) begin
            result = -limit;
        end else begin
            result = value;
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// File: hw/snd_cen_gen.sv
// DAC clock enable ring
`default_nettype none

`include "snd_defs.svh"

module snd_cen_gen (
    input  logic clk_dac,
    input  logic rst,
    output logic cen_o
);

    localparam int RING_W = `SND_CEN_DIV;

    // Reset phase sits two positions above bit 0
    // so the first enable comes on the second edge after rst falls
    localparam logic [RING_W-1:0] RING_RST = RING_W'(1) << (RING_W - 2);

    logic [RING_W-1:0] ring_q;

    // Rotate left once per clk_dac
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            ring_q <= RING_RST;
        end else begin
            ring_q <= {ring_q[RING_W-2:0], ring_q[RING_W-1]};
        end
    end

    // Shared enable for both channels
    assign cen_o = ring_q[0];

    // One token circulates forever
    ring_onehot_a: assert property (
        @(posedge clk_dac) disable iff (rst)
        $onehot(ring_q)
    );

    // Enable is a single-cycle pulse
    cen_single_a: assert property (
        @(posedge clk_dac) disable iff (rst)
        cen_o |=> !cen_o
    );

endmodule

`default_nettype wire

// File: hw/snd_sigma_delta.sv
// Second-order sigma-delta channel
`default_nettype none

`include "snd_defs.svh"

module snd_sigma_delta
    import snd_pcm_pkg::*;
    import snd_dac_pkg::*;
#(
    parameter bit SIGNED_SND = 1'b1
) (
    input  logic   clk_dac,
    input  logic   rst,
    input  logic   cen_i,
    input  pcm16_t pcm_i,
    output logic   pwm_o
);

    localparam int PCM_W  = $bits(pcm16_t);
    localparam int FS_BIT = $bits(pcm_pad_t) - 1;

    // Feedback weight equals the pad word's MSB, 2^19
    localparam sd_fb_t FB_FULL = sd_fb_t'(1) <<< FS_BIT;

    // Saturation levels
    // Clipping lets the loop recover after inputs at the very
    // edge of the range, where an ideal double integrator drifts
    localparam sd_acc_t SAT1 = 2 * FB_FULL;
    localparam sd_acc_t SAT2 = 3 * FB_FULL;

    // Stability bound, 2^21
    localparam sd_acc_t ACC_BOUND = 4 * FB_FULL;

    pcm16_t   pcm_conv;
    pcm_pad_t pcm_pad;
    pcm_pad_t x_q;

    sd_acc_t  x_ext;
    sd_fb_t   fb;
    sd_acc_t  acc1_sum;
    sd_acc_t  acc1_d;
    sd_acc_t  acc1_q;
    sd_acc_t  acc2_sum;
    sd_acc_t  acc2_d;
    sd_acc_t  acc2_q;

    logic     pwm_q;

    // Offset binary conversion
    // A signed core has its MSB flipped so that the most negative
    // sample maps to zero density
    always_comb begin
        pcm_conv = {pcm_i[PCM_W-1] ^ SIGNED_SND, pcm_i[PCM_W-2:0]};
        pcm_pad  = {1'b0, pcm_conv, {`SND_PAD_LSB{1'b0}}};
    end

    // Latched sample, zero extended into the integrator width
    assign x_ext = sd_acc_t'(x_q);

    // Previous output bit back into both integrators
    assign fb = pwm_q ? FB_FULL : '0;

    // Loop filter
    // First integrator accumulates input minus feedback,
    // second accumulates the new first value minus feedback
    always_comb begin
        acc1_sum = acc1_q + x_ext - fb;
        acc1_d   = sd_clip(acc1_sum, SAT1);
        acc2_sum = acc2_q + acc1_d - fb;
        acc2_d   = sd_clip(acc2_sum, SAT2);
    end

    // Everything advances together on the enable
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            x_q    <= '0;
            acc1_q <= '0;
            acc2_q <= '0;
            pwm_q  <= 1'b0;
        end else if (cen_i) begin
            x_q    <= pcm_pad;
            acc1_q <= acc1_d;
            acc2_q <= acc2_d;
            // Quantizer, high when the second integrator is non-negative
            pwm_q  <= ~acc2_d[`SND_ACC_W-1];
        end
    end

    assign pwm_o = pwm_q;

    // Integrators never run away
    acc1_bound_a: assert property (
        @(posedge clk_dac) disable iff (rst)
        (acc1_q <= ACC_BOUND) && (acc1_q >= -ACC_BOUND)
    );

    acc2_bound_a: assert property (
        @(posedge clk_dac) disable iff (rst)
        (acc2_q <= ACC_BOUND) && (acc2_q >= -ACC_BOUND)
    );

    // Output bit only moves on an enable edge
    pwm_on_cen_a: assert property (
        @(posedge clk_dac) disable iff (rst)
        !$past(cen_i) |-> $stable(pwm_o)
    );

endmodule

`default_nettype wire

// File: hw/snd_dac_top.sv
// Sigma-delta sound output
`default_nettype none

module snd_dac_top
    import snd_pcm_pkg::*;
#(
    parameter bit SIGNED_SND = 1'b1,
    parameter bit STEREO     = 1'b1
) (
    input  logic      clk_dac,
    input  logic      rst,
    input  pcm_pair_t snd_i,
    output logic      snd_pwm_left_o,
    output logic      snd_pwm_right_o
);

    // Shared modulator enable
    logic cen_dac;

    snd_cen_gen u_cen (
        .clk_dac ( clk_dac ),
        .rst     ( rst     ),
        .cen_o   ( cen_dac )
    );

    // Left channel always present
    snd_sigma_delta #(
        .SIGNED_SND ( SIGNED_SND )
    ) u_sd_left (
        .clk_dac ( clk_dac        ),
        .rst     ( rst            ),
        .cen_i   ( cen_dac        ),
        .pcm_i   ( snd_i.left     ),
        .pwm_o   ( snd_pwm_left_o )
    );

    generate
        if (STEREO) begin : g_stereo
            // Independent right modulator on the same enable
            snd_sigma_delta #(
                .SIGNED_SND ( SIGNED_SND )
            ) u_sd_right (
                .clk_dac ( clk_dac         ),
                .rst     ( rst             ),
                .cen_i   ( cen_dac         ),
                .pcm_i   ( snd_i.right     ),
                .pwm_o   ( snd_pwm_right_o )
            );
        end else begin : g_mono
            // Mono core, both pins carry the left stream
            assign snd_pwm_right_o = snd_pwm_left_o;
        end
    endgenerate

endmodule

`default_nettype wire

// File: testbench/snd_density_mon.sv
// Output density monitor
`default_nettype none

`include "snd_defs.svh"

module snd_density_mon #(
    parameter string PIN_NAME = "pin"
) (
    input  logic clk_dac,
    input  logic rst,
    input  logic pwm_i,
    output logic win_done_o,
    output int   win_cnt_o,
    output int   err_cnt_o
);

    int   cyc;
    int   ones;
    int   cen_seen;
    int   err_cnt = 0;
    logic cen_model;

    // Reference enable schedule, rebuilt from the reset release
    // First enable two edges after rst falls, then every SND_CEN_DIV
    assign cen_model = !rst && (cyc >= 2) && (((cyc - 2) % `SND_CEN_DIV) == 0);

    // Count ones once per enable, one window at a time
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            cyc        <= 0;
            ones       <= 0;
            cen_seen   <= 0;
            win_cnt_o  <= 0;
            win_done_o <= 1'b0;
        end else begin
            cyc        <= cyc + 1;
            win_done_o <= 1'b0;
            if (cen_model) begin
                if (cen_seen == `SND_WIN - 1) begin
                    win_cnt_o  <= ones + int'(pwm_i);
                    win_done_o <= 1'b1;
                    ones       <= 0;
                    cen_seen   <= 0;
                end else begin
                    ones     <= ones + int'(pwm_i);
                    cen_seen <= cen_seen + 1;
                end
            end
        end
    end

    assign err_cnt_o = err_cnt;

    // Quiet during reset and until the first enable has acted
    reset_level_a: assert property (
        @(posedge clk_dac) (rst || cyc <= 2) |-> !pwm_i
    ) else begin
        err_cnt++;
        $display("%s went high before the first modulator enable at %0t", PIN_NAME, $time);
    end

    // Every transition follows a predicted enable cycle
    cen_phase_a: assert property (
        @(posedge clk_dac) disable iff (rst)
        !$stable(pwm_i) |-> $past(cen_model)
    ) else begin
        err_cnt++;
        $display("%s changed off the enable schedule at %0t", PIN_NAME, $time);
    end

endmodule

`default_nettype wire

// File: testbench/tb_snd_dac_top.sv
// Sound DAC testbench
`default_nettype none

`include "snd_defs.svh"

module tb_snd_dac_top
    import snd_pcm_pkg::*;
();

    // Ten mixed phases, then the long random run
    localparam int     FIRST_PHASES = 10;
    localparam int     LONG_PHASES  = 20;
    localparam int     NUM_PHASES   = FIRST_PHASES + LONG_PHASES;
    localparam int     WIN_CYCLES   = `SND_WIN * `SND_CEN_DIV;
    localparam longint TIMEOUT      = (longint'(NUM_PHASES) * 2 * WIN_CYCLES + 100) * 10;

    logic        clk_dac;
    logic        rst;
    pcm_pair_t   snd_st;
    pcm_pair_t   snd_mono;
    logic        st_left;
    logic        st_right;
    logic        mono_left;
    logic        mono_right;

    logic        win_done;
    int          cnt_st_l;
    int          cnt_st_r;
    int          cnt_mono_l;
    int          cnt_mono_r;
    int          err_st_l;
    int          err_st_r;
    int          err_mono_l;
    int          err_mono_r;

    logic [31:0] rng;
    logic [15:0] cur_st_l;
    logic [15:0] cur_st_r;
    logic [15:0] cur_mono_l;
    int          errors;
    int          copy_errors;
    int          checks;

    always #5 clk_dac = ~clk_dac;

    snd_dac_top #(
        .SIGNED_SND ( 1'b1 ),
        .STEREO     ( 1'b1 )
    ) u_dut (
        .clk_dac         ( clk_dac  ),
        .rst             ( rst      ),
        .snd_i           ( snd_st   ),
        .snd_pwm_left_o  ( st_left  ),
        .snd_pwm_right_o ( st_right )
    );

    snd_dac_top #(
        .SIGNED_SND ( 1'b0 ),
        .STEREO     ( 1'b0 )
    ) u_dut_mono (
        .clk_dac         ( clk_dac    ),
        .rst             ( rst        ),
        .snd_i           ( snd_mono   ),
        .snd_pwm_left_o  ( mono_left  ),
        .snd_pwm_right_o ( mono_right )
    );

    snd_density_mon #(.PIN_NAME("u_dut left")) mon_st_left (
        .clk_dac    ( clk_dac  ),
        .rst        ( rst      ),
        .pwm_i      ( st_left  ),
        .win_done_o ( win_done ),
        .win_cnt_o  ( cnt_st_l ),
        .err_cnt_o  ( err_st_l )
    );

    snd_density_mon #(.PIN_NAME("u_dut right")) mon_st_right (
        .clk_dac    ( clk_dac  ),
        .rst        ( rst      ),
        .pwm_i      ( st_right ),
        .win_done_o (          ),
        .win_cnt_o  ( cnt_st_r ),
        .err_cnt_o  ( err_st_r )
    );

    snd_density_mon #(.PIN_NAME("u_dut_mono left")) mon_mono_left (
        .clk_dac    ( clk_dac    ),
        .rst        ( rst        ),
        .pwm_i      ( mono_left  ),
        .win_done_o (            ),
        .win_cnt_o  ( cnt_mono_l ),
        .err_cnt_o  ( err_mono_l )
    );

    snd_density_mon #(.PIN_NAME("u_dut_mono right")) mon_mono_right (
        .clk_dac    ( clk_dac    ),
        .rst        ( rst        ),
        .pwm_i      ( mono_right ),
        .win_done_o (            ),
        .win_cnt_o  ( cnt_mono_r ),
        .err_cnt_o  ( err_mono_r )
    );

    // Mono build carries the left stream on both pins
    mono_copy_a: assert property (
        @(posedge clk_dac) mono_right == mono_left
    ) else begin
        copy_errors++;
        $display("Mono DUT right pin differs from its left pin at %0t", $time);
    end

    // Numerical Recipes LCG constants
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Ones per window from the density rule
    // A signed core is offset by half scale first
    function automatic int expected_ones(input logic [15:0] value, input bit is_signed);
        int s;
        s = is_signed ? int'(value ^ 16'h8000) : int'(value);
        return (s * `SND_WIN + 32768) / 65536;
    endfunction

    function automatic string test_name(input int p, input bit stereo_dut);
        string name;
        if (p >= FIRST_PHASES) begin
            name = "long_run";
        end else if (!stereo_dut) begin
            name = "unsigned_density";
        end else if (p < 3) begin
            name = "signed_density";
        end else begin
            name = "stereo_independence";
        end
        return name;
    endfunction

    task automatic draw_sample(output logic [15:0] value);
        rng   = lcg_next(rng);
        value = rng[31:16];
    endtask

    // New sample levels for one phase, both DUTs at once
    task automatic drive_phase(input int p);
        logic [15:0] mono_r;
        draw_sample(cur_mono_l);
        draw_sample(mono_r);
        draw_sample(cur_st_l);
        draw_sample(cur_st_r);
        if (cur_st_r == cur_st_l) begin
            cur_st_r = ~cur_st_l;
        end
        // Fixed corner values lead the sequence
        if (p == 0) begin
            cur_mono_l = 16'h0000;
            cur_st_l   = 16'h8000;
            cur_st_r   = 16'h8000;
        end else if (p == 1) begin
            cur_mono_l = 16'hFFFF;
            cur_st_l   = 16'h0000;
            cur_st_r   = 16'h0000;
        end else if (p == 2) begin
            cur_st_l   = 16'h7FFF;
            cur_st_r   = 16'h7FFF;
        end
        snd_st.left    <= cur_st_l;
        snd_st.right   <= cur_st_r;
        snd_mono.left  <= cur_mono_l;
        snd_mono.right <= mono_r;
    endtask

    // Returns on a falling edge while the window result is stable
    task automatic wait_windows(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge clk_dac);
            if (win_done) begin
                seen++;
            end
        end
    endtask

    task automatic check_count(input string test, input string pin,
                               input int expected, input int actual);
        checks++;
        assert ((actual >= expected - 2) && (actual <= expected + 2)) else begin
            errors++;
            $display("ERROR %s %s: expected %0d ones, actual %0d", test, pin, expected, actual);
        end
    endtask

    task automatic check_phase(input int p);
        int exp_mono;
        exp_mono = expected_ones(cur_mono_l, 1'b0);
        check_count(test_name(p, 1'b1), "u_dut left", expected_ones(cur_st_l, 1'b1), cnt_st_l);
        check_count(test_name(p, 1'b1), "u_dut right", expected_ones(cur_st_r, 1'b1), cnt_st_r);
        check_count(test_name(p, 1'b0), "u_dut_mono left", exp_mono, cnt_mono_l);
        check_count(test_name(p, 1'b0), "u_dut_mono right", exp_mono, cnt_mono_r);
    endtask

    initial begin
        int total;
        clk_dac     = 1'b0;
        rst         = 1'b1;
        snd_st      = '0;
        snd_mono    = '0;
        rng         = 32'd39;
        cur_st_l    = '0;
        cur_st_r    = '0;
        cur_mono_l  = '0;
        errors      = 0;
        copy_errors = 0;
        checks      = 0;
        repeat (2) begin
            @(posedge clk_dac);
        end
        rst <= 1'b0;
        // First window of a phase settles, the second is measured
        for (int p = 0; p < NUM_PHASES; p++) begin
            drive_phase(p);
            wait_windows(2);
            check_phase(p);
            @(posedge clk_dac);
        end
        total = errors + copy_errors + err_st_l + err_st_r + err_mono_l + err_mono_r;
        $display("Density checks %0d, density errors %0d, copy errors %0d, monitor errors %0d",
                 checks, errors, copy_errors, err_st_l + err_st_r + err_mono_l + err_mono_r);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Two windows per phase plus margin
    initial begin
        #(TIMEOUT);
        $display("Watchdog expired at %0t before all density windows completed", $time);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: snd_dac_top.f
+incdir+hw
hw/snd_pcm_pkg.sv
hw/snd_dac_pkg.sv
hw/snd_cen_gen.sv
hw/snd_sigma_delta.sv
hw/snd_dac_top.sv
testbench/snd_density_mon.sv
testbench/tb_snd_dac_top.sv

// File: Bender.yml
package:
  name: snd_dac

export_include_dirs:
  - hw

sources:
  # Synthesizable sound output path
  - include_dirs:
      - hw
    files:
      - hw/snd_pcm_pkg.sv
      - hw/snd_dac_pkg.sv
      - hw/snd_cen_gen.sv
      - hw/snd_sigma_delta.sv
      - hw/snd_dac_top.sv

  # Simulation only
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/snd_density_mon.sv
      - testbench/tb_snd_dac_top.sv
